// ==== source/cpu_pkg.sv ====
package cpu_pkg;

        localparam int WORD_WIDTH     = 16;
        localparam int REG_ADDR_WIDTH = 2;
        localparam int NUM_REGS       = 4;
        localparam int LINK_REG       = 2;   // JAL return address

        typedef logic [WORD_WIDTH-1:0]     word_t;
        typedef logic [REG_ADDR_WIDTH-1:0] reg_addr_t;

        // ------------------------------------------------------------
        // instruction encoding
        // ------------------------------------------------------------
        typedef enum logic [3:0] {
                OP_BNE   = 4'd0,
                OP_BEQ   = 4'd1,
                OP_ADI   = 4'd4,
                OP_ORI   = 4'd5,
                OP_LHI   = 4'd6,
                OP_LWD   = 4'd7,
                OP_SWD   = 4'd8,
                OP_JMP   = 4'd9,
                OP_JAL   = 4'd10,
                OP_RTYPE = 4'd15
        } opcode_e;

        typedef enum logic [5:0] {
                FN_ADD = 6'd0,
                FN_SUB = 6'd1,
                FN_AND = 6'd2,
                FN_ORR = 6'd3,
                FN_WWD = 6'd28,
                FN_HLT = 6'd29
        } func_e;

        typedef enum logic [2:0] {
                ALU_ADD,
                ALU_SUB,
                ALU_AND,
                ALU_OR,
                ALU_LHI   // immediate into the upper byte
        } alu_op_e;

        typedef struct packed {
                opcode_e   opcode;
                reg_addr_t rs;
                reg_addr_t rt;
                reg_addr_t rd;
                func_e     func;
        } r_fmt_t;

        typedef struct packed {
                opcode_e   opcode;
                reg_addr_t rs;
                reg_addr_t rt;
                logic [7:0] imm;
        } i_fmt_t;

        typedef struct packed {
                opcode_e     opcode;
                logic [11:0] target;
        } j_fmt_t;

        typedef union packed {
                r_fmt_t r;
                i_fmt_t i;
                j_fmt_t j;
        } instr_u;

        // ------------------------------------------------------------
        // pipeline bundles
        // ------------------------------------------------------------
        typedef enum logic [1:0] {
                WB_ALU,
                WB_MEM,
                WB_PC1
        } wb_sel_e;

        typedef struct packed {
                alu_op_e alu_op;
                logic    imm_sel;     // operand b is the immediate
                logic    mem_read;
                logic    mem_write;
                logic    reg_write;
                wb_sel_e wb_sel;
                logic    branch;
                logic    branch_eq;   // BEQ, else BNE
                logic    wwd;
                logic    halt;
        } ctrl_t;

        typedef struct packed {
                logic      valid;
                ctrl_t     ctrl;
                word_t     pc;
                word_t     imm;
                reg_addr_t rs;
                reg_addr_t rt;
                reg_addr_t dest;
        } id_ex_t;

        typedef struct packed {
                logic      valid;
                ctrl_t     ctrl;
                word_t     pc;
                word_t     result;
                word_t     store_data;
                reg_addr_t dest;
        } ex_mem_t;

        typedef struct packed {
                logic      valid;
                ctrl_t     ctrl;
                word_t     pc;
                word_t     result;
                word_t     load_data;
                reg_addr_t dest;
                word_t     out_data;   // WWD value
        } mem_wb_t;

        typedef struct packed {
                logic      valid;
                reg_addr_t addr;
        } dest_t;

        typedef struct packed {
                logic      en;
                reg_addr_t addr;
                word_t     data;
        } rf_write_t;

        typedef struct packed {
                logic  valid;
                word_t target;
        } redirect_t;

        typedef struct packed {
                logic  read;
                logic  write;
                word_t addr;
                word_t wdata;
        } dmem_req_t;

endpackage

// ==== source/fetch_unit.sv ====
module fetch_unit #(
        parameter cpu_pkg::word_t RESET_PC = '0
) (
        input  logic               clk,
        input  logic               reset_n,
        input  logic               i_stall,
        input  logic               i_flush,
        input  cpu_pkg::redirect_t i_redirect,
        input  cpu_pkg::word_t     i_instr,
        output cpu_pkg::word_t     o_pc,
        output cpu_pkg::word_t     o_id_pc,
        output cpu_pkg::instr_u    o_id_instr,
        output logic               o_id_valid
);

        cpu_pkg::word_t pc;

        // program counter
        always_ff @(posedge clk) begin
                if (!reset_n)
                        pc <= RESET_PC;
                else if (i_redirect.valid)
                        pc <= i_redirect.target;   // branch or jump wins over stall
                else if (!i_stall)
                        pc <= pc + 1'b1;
        end

        // ------------------------------------------------------------
        // fetch-to-decode register
        // ------------------------------------------------------------
        always_ff @(posedge clk) begin
                if (!reset_n) begin
                        o_id_valid <= 1'b0;
                end else if (i_flush) begin
                        o_id_valid <= 1'b0;   // bubble
                end else if (!i_stall) begin
                        o_id_valid <= 1'b1;
                        o_id_pc    <= pc;
                        o_id_instr <= i_instr;
                end
        end

        assign o_pc = pc;

endmodule

// ==== source/control_unit.sv ====
module control_unit (
        input  logic               clk,
        input  logic               reset_n,
        input  cpu_pkg::instr_u    i_instr,
        input  cpu_pkg::word_t     i_pc,
        input  logic               i_valid,
        input  cpu_pkg::word_t     i_rs_data,
        input  cpu_pkg::redirect_t i_branch,
        input  cpu_pkg::dest_t     i_ex_dest,
        input  cpu_pkg::dest_t     i_mem_dest,
        input  cpu_pkg::rf_write_t i_wb,
        output cpu_pkg::reg_addr_t o_rs_addr,
        output cpu_pkg::reg_addr_t o_rt_addr,
        output cpu_pkg::id_ex_t    o_id,
        output logic               o_stall,
        output logic               o_flush_fetch,
        output logic               o_flush_decode,
        output cpu_pkg::redirect_t o_redirect
);

        cpu_pkg::opcode_e   op;
        cpu_pkg::func_e     func;
        cpu_pkg::ctrl_t     ctrl;
        cpu_pkg::word_t     imm;
        cpu_pkg::reg_addr_t dest;
        cpu_pkg::dest_t     wb_dest;
        logic               r_alu, uses_rs, uses_rt, is_jump;
        logic               hazard, jump_dec, halt_dec, halt_seen;

        function automatic logic hits(input cpu_pkg::dest_t d, input cpu_pkg::reg_addr_t a);
                return d.valid && d.addr == a;
        endfunction

        assign op    = i_instr.r.opcode;
        assign func  = i_instr.r.func;
        assign r_alu = op == cpu_pkg::OP_RTYPE &&
                       func inside {cpu_pkg::FN_ADD, cpu_pkg::FN_SUB,
                                    cpu_pkg::FN_AND, cpu_pkg::FN_ORR};

        // ------------------------------------------------------------
        // decode
        // ------------------------------------------------------------
        always_comb begin
                ctrl           = '0;
                ctrl.reg_write = r_alu || op inside {cpu_pkg::OP_ADI, cpu_pkg::OP_ORI,
                                                     cpu_pkg::OP_LHI, cpu_pkg::OP_LWD,
                                                     cpu_pkg::OP_JAL};
                ctrl.imm_sel   = op inside {cpu_pkg::OP_ADI, cpu_pkg::OP_ORI, cpu_pkg::OP_LHI,
                                            cpu_pkg::OP_LWD, cpu_pkg::OP_SWD};
                ctrl.mem_read  = op == cpu_pkg::OP_LWD;
                ctrl.mem_write = op == cpu_pkg::OP_SWD;
                ctrl.branch    = op inside {cpu_pkg::OP_BEQ, cpu_pkg::OP_BNE};
                ctrl.branch_eq = op == cpu_pkg::OP_BEQ;
                ctrl.wwd       = op == cpu_pkg::OP_RTYPE && func == cpu_pkg::FN_WWD;
                ctrl.halt      = op == cpu_pkg::OP_RTYPE && func == cpu_pkg::FN_HLT;
                if (op == cpu_pkg::OP_LWD)
                        ctrl.wb_sel = cpu_pkg::WB_MEM;
                else if (op == cpu_pkg::OP_JAL)
                        ctrl.wb_sel = cpu_pkg::WB_PC1;
                if (op == cpu_pkg::OP_ORI || (r_alu && func == cpu_pkg::FN_ORR))
                        ctrl.alu_op = cpu_pkg::ALU_OR;
                else if (op == cpu_pkg::OP_LHI)
                        ctrl.alu_op = cpu_pkg::ALU_LHI;
                else if (r_alu && func == cpu_pkg::FN_SUB)
                        ctrl.alu_op = cpu_pkg::ALU_SUB;
                else if (r_alu && func == cpu_pkg::FN_AND)
                        ctrl.alu_op = cpu_pkg::ALU_AND;
        end

        always_comb begin
                if (ctrl.wwd)
                        imm = i_rs_data;   // output value rides in the imm slot
                else if (op == cpu_pkg::OP_ORI)
                        imm = {8'h00, i_instr.i.imm};   // ORI zero-extends
                else
                        imm = {{8{i_instr.i.imm[7]}}, i_instr.i.imm};
        end

        assign dest = (op == cpu_pkg::OP_RTYPE) ? i_instr.r.rd :
                      (op == cpu_pkg::OP_JAL)   ? cpu_pkg::reg_addr_t'(cpu_pkg::LINK_REG) :
                                                  i_instr.i.rt;

        assign uses_rs = r_alu || ctrl.wwd || op inside {cpu_pkg::OP_ADI, cpu_pkg::OP_ORI,
                                                         cpu_pkg::OP_LWD, cpu_pkg::OP_SWD,
                                                         cpu_pkg::OP_BEQ, cpu_pkg::OP_BNE};
        assign uses_rt = r_alu || op inside {cpu_pkg::OP_SWD, cpu_pkg::OP_BEQ, cpu_pkg::OP_BNE};
        assign is_jump = op inside {cpu_pkg::OP_JMP, cpu_pkg::OP_JAL};

        // ------------------------------------------------------------
        // hazards, redirects, halt
        // ------------------------------------------------------------
        assign wb_dest = '{valid: i_wb.en, addr: i_wb.addr};
        assign hazard  = i_valid &&
                ((uses_rs && (hits(i_ex_dest, o_rs_addr) || hits(i_mem_dest, o_rs_addr) ||
                              hits(wb_dest, o_rs_addr))) ||
                 (uses_rt && (hits(i_ex_dest, o_rt_addr) || hits(i_mem_dest, o_rt_addr) ||
                              hits(wb_dest, o_rt_addr))));

        assign jump_dec = i_valid && is_jump && !i_branch.valid;
        assign halt_dec = i_valid && ctrl.halt && !i_branch.valid;

        always_ff @(posedge clk) begin
                if (!reset_n)
                        halt_seen <= 1'b0;
                else if (halt_dec)
                        halt_seen <= 1'b1;   // sticky until reset
        end

        assign o_rs_addr      = i_instr.r.rs;
        assign o_rt_addr      = i_instr.r.rt;
        assign o_redirect     = i_branch.valid ? i_branch :
                                '{valid: jump_dec, target: {i_pc[15:12], i_instr.j.target}};
        assign o_stall        = (hazard && !i_branch.valid) || halt_dec || halt_seen;
        assign o_flush_fetch  = o_redirect.valid || halt_dec || halt_seen;
        assign o_flush_decode = i_branch.valid;

        assign o_id = '{valid: i_valid && !hazard, ctrl: ctrl, pc: i_pc, imm: imm,
                        rs: i_instr.r.rs, rt: i_instr.r.rt, dest: dest};

endmodule

// ==== source/register_file.sv ====
module register_file (
        input  logic               clk,
        input  logic               reset_n,
        input  cpu_pkg::reg_addr_t i_rs_addr,
        input  cpu_pkg::reg_addr_t i_rt_addr,
        input  cpu_pkg::rf_write_t i_write,
        output cpu_pkg::word_t     o_rs_data,
        output cpu_pkg::word_t     o_rt_data
);

        cpu_pkg::word_t regs [cpu_pkg::NUM_REGS];

        always_ff @(posedge clk) begin
                if (!reset_n) begin
                        foreach (regs[k])
                                regs[k] <= '0;
                end else if (i_write.en) begin
                        regs[i_write.addr] <= i_write.data;
                end
        end

        // reads see the old value during a write; decode stalls past that case
        assign o_rs_data = regs[i_rs_addr];
        assign o_rt_data = regs[i_rt_addr];

endmodule

// ==== source/execute_unit.sv ====
module execute_unit (
        input  logic               clk,
        input  logic               reset_n,
        input  logic               i_flush,
        input  cpu_pkg::id_ex_t    i_id,
        input  cpu_pkg::word_t     i_rs_data,
        input  cpu_pkg::word_t     i_rt_data,
        output cpu_pkg::redirect_t o_branch,
        output cpu_pkg::dest_t     o_ex_dest,
        output cpu_pkg::dest_t     o_mem_dest,
        output cpu_pkg::ex_mem_t   o_ex_mem
);

        cpu_pkg::id_ex_t  ex;
        cpu_pkg::ex_mem_t mem;
        cpu_pkg::word_t   rs_val, rt_val;
        cpu_pkg::word_t   alu_b, alu_y;
        logic             taken;

        // ------------------------------------------------------------
        // decode-to-execute register
        // ------------------------------------------------------------
        always_ff @(posedge clk) begin
                if (!reset_n) begin
                        ex.valid <= 1'b0;
                end else begin
                        ex       <= i_id;
                        ex.valid <= i_id.valid && !i_flush;   // killed by a taken branch
                end
        end

        always_ff @(posedge clk) begin
                rs_val <= i_rs_data;
                rt_val <= i_rt_data;
        end

        // ALU
        assign alu_b = ex.ctrl.imm_sel ? ex.imm : rt_val;

        always_comb begin
                case (ex.ctrl.alu_op)
                cpu_pkg::ALU_SUB: alu_y = rs_val - alu_b;
                cpu_pkg::ALU_AND: alu_y = rs_val & alu_b;
                cpu_pkg::ALU_OR:  alu_y = rs_val | alu_b;
                cpu_pkg::ALU_LHI: alu_y = {alu_b[7:0], 8'h00};
                default:          alu_y = rs_val + alu_b;
                endcase
        end

        // BEQ taken on equal, BNE on not equal
        assign taken    = ex.valid && ex.ctrl.branch && ((rs_val == rt_val) == ex.ctrl.branch_eq);
        assign o_branch = '{valid: taken, target: ex.pc + 1'b1 + ex.imm};

        // ------------------------------------------------------------
        // execute-to-memory register
        // ------------------------------------------------------------
        always_ff @(posedge clk) begin
                if (!reset_n) begin
                        mem.valid <= 1'b0;
                        mem.ctrl  <= '0;
                end else begin
                        mem.valid      <= ex.valid;
                        mem.ctrl       <= ex.valid ? ex.ctrl : '0;   // keeps bubbles off the bus
                        mem.pc         <= ex.pc;
                        mem.result     <= alu_y;
                        mem.store_data <= ex.ctrl.wwd ? ex.imm : rt_val;   // rt for SWD
                        mem.dest       <= ex.dest;
                end
        end

        assign o_ex_dest  = '{valid: ex.valid && ex.ctrl.reg_write, addr: ex.dest};
        assign o_mem_dest = '{valid: mem.valid && mem.ctrl.reg_write, addr: mem.dest};
        assign o_ex_mem   = mem;

endmodule

// ==== source/writeback_unit.sv ====
module writeback_unit (
        input  logic               clk,
        input  logic               reset_n,
        input  cpu_pkg::ex_mem_t   i_ex_mem,
        input  cpu_pkg::word_t     i_rdata,
        output cpu_pkg::rf_write_t o_rf_write,
        output cpu_pkg::word_t     o_output_port,
        output logic               o_halted,
        output cpu_pkg::word_t     o_num_inst
);

        cpu_pkg::mem_wb_t wb;
        cpu_pkg::word_t   wdata;

        // load data lands in the memory-to-write-back register
        always_ff @(posedge clk) begin
                if (!reset_n) begin
                        wb.valid <= 1'b0;
                        wb.ctrl  <= '0;
                end else begin
                        wb.valid     <= i_ex_mem.valid;
                        wb.ctrl      <= i_ex_mem.ctrl;
                        wb.pc        <= i_ex_mem.pc;
                        wb.result    <= i_ex_mem.result;
                        wb.load_data <= i_rdata;
                        wb.dest      <= i_ex_mem.dest;
                        wb.out_data  <= i_ex_mem.store_data;
                end
        end

        always_comb begin
                case (wb.ctrl.wb_sel)
                cpu_pkg::WB_MEM: wdata = wb.load_data;
                cpu_pkg::WB_PC1: wdata = wb.pc + 1'b1;   // JAL link
                default:         wdata = wb.result;
                endcase
        end

        assign o_rf_write = '{en: wb.valid && wb.ctrl.reg_write, addr: wb.dest, data: wdata};

        // ------------------------------------------------------------
        // retirement
        // ------------------------------------------------------------
        always_ff @(posedge clk) begin
                if (!reset_n) begin
                        o_output_port <= '0;
                        o_halted      <= 1'b0;
                        o_num_inst    <= '0;
                end else if (wb.valid) begin
                        o_num_inst <= o_num_inst + 1'b1;
                        if (wb.ctrl.wwd)
                                o_output_port <= wb.out_data;
                        if (wb.ctrl.halt)
                                o_halted <= 1'b1;
                end
        end

endmodule

// ==== source/cpu_core.sv ====
module cpu_core #(
        parameter cpu_pkg::word_t RESET_PC = '0
) (
        input  logic               clk,
        input  logic               reset_n,
        output cpu_pkg::word_t     o_i_address,
        input  cpu_pkg::word_t     i_i_data,
        output cpu_pkg::dmem_req_t o_dmem,
        input  cpu_pkg::word_t     i_d_rdata,
        output cpu_pkg::word_t     o_output_port,
        output logic               o_halted,
        output cpu_pkg::word_t     o_num_inst
);

        cpu_pkg::word_t     id_pc, rs_data, rt_data;
        cpu_pkg::instr_u    id_instr;
        cpu_pkg::reg_addr_t rs_addr, rt_addr;
        cpu_pkg::id_ex_t    id;
        cpu_pkg::redirect_t redirect, branch;
        cpu_pkg::dest_t     ex_dest, mem_dest;
        cpu_pkg::ex_mem_t   ex_mem;
        cpu_pkg::rf_write_t rf_write;
        logic               id_valid, stall, flush_fetch, flush_decode;

        fetch_unit #(.RESET_PC(RESET_PC)) u_fetch (
                .clk        (clk),
                .reset_n    (reset_n),
                .i_stall    (stall),
                .i_flush    (flush_fetch),
                .i_redirect (redirect),
                .i_instr    (i_i_data),
                .o_pc       (o_i_address),
                .o_id_pc    (id_pc),
                .o_id_instr (id_instr),
                .o_id_valid (id_valid)
        );

        control_unit u_control (
                .clk            (clk),
                .reset_n        (reset_n),
                .i_instr        (id_instr),
                .i_pc           (id_pc),
                .i_valid        (id_valid),
                .i_rs_data      (rs_data),
                .i_branch       (branch),
                .i_ex_dest      (ex_dest),
                .i_mem_dest     (mem_dest),
                .i_wb           (rf_write),
                .o_rs_addr      (rs_addr),
                .o_rt_addr      (rt_addr),
                .o_id           (id),
                .o_stall        (stall),
                .o_flush_fetch  (flush_fetch),
                .o_flush_decode (flush_decode),
                .o_redirect     (redirect)
        );

        register_file u_regs (
                .clk       (clk),
                .reset_n   (reset_n),
                .i_rs_addr (rs_addr),
                .i_rt_addr (rt_addr),
                .i_write   (rf_write),
                .o_rs_data (rs_data),
                .o_rt_data (rt_data)
        );

        execute_unit u_execute (
                .clk        (clk),
                .reset_n    (reset_n),
                .i_flush    (flush_decode),
                .i_id       (id),
                .i_rs_data  (rs_data),
                .i_rt_data  (rt_data),
                .o_branch   (branch),
                .o_ex_dest  (ex_dest),
                .o_mem_dest (mem_dest),
                .o_ex_mem   (ex_mem)
        );

        // data request straight out of the memory stage
        assign o_dmem = '{read: ex_mem.ctrl.mem_read, write: ex_mem.ctrl.mem_write,
                          addr: ex_mem.result, wdata: ex_mem.store_data};

        writeback_unit u_writeback (
                .clk           (clk),
                .reset_n       (reset_n),
                .i_ex_mem      (ex_mem),
                .i_rdata       (i_d_rdata),
                .o_rf_write    (rf_write),
                .o_output_port (o_output_port),
                .o_halted      (o_halted),
                .o_num_inst    (o_num_inst)
        );

endmodule

// ==== sim/cpu_tb_programs.svh ====
`ifndef CPU_TB_PROGRAMS_SVH
`define CPU_TB_PROGRAMS_SVH

// each row holds name, word count, program words, output count, outputs and retired count
task automatic fill_test_table();
        // ADI ADI ADD WWD SUB AND ORR WWD LHI ORI WWD HLT
        // every step reads the result just written, so decode stalls
        add_test("arith", 12,
                 {16'h417F, 16'h46FE, 16'hF6C0, 16'hFC1C, 16'hFB01, 16'hF342,
                  16'hF483, 16'hF81C, 16'h63A5, 16'h5FC3, 16'hFC1C, 16'hF01D},
                 3, {16'h00FC, 16'hFF81, 16'hA5C3}, 16'd12);

        // store 0x1234 at 0x43 and load it back
        // then load 0x30 from the random fill
        add_test("memory", 9,
                 {16'h4140, 16'h6212, 16'h5A34, 16'h8603, 16'h7703, 16'hFC1C,
                  16'h74F0, 16'hF01C, 16'hF01D},
                 2, {16'h1234, dmem[8'h30]}, 16'd9);

        // ------------------------------------------------------------
        // control flow
        // ------------------------------------------------------------
        // BEQ taken over two WWDs, BNE falls through, BNE taken, BEQ falls through
        add_test("branch", 14,
                 {16'h4107, 16'h4207, 16'h1602, 16'hF41C, 16'hF81C, 16'h0601,
                  16'h4321, 16'hFC1C, 16'h0D01, 16'hF41C, 16'h1D01, 16'h5C0C,
                  16'hF01C, 16'hF01D},
                 2, {16'h0021, 16'h002D}, 16'd11);

        // JMP 3, JAL 6 links pc plus one into r2, WWD after HLT must stay silent
        add_test("jump", 12,
                 {16'h9003, 16'h4101, 16'hF41C, 16'hA006, 16'h4101, 16'hF41C,
                  16'hF81C, 16'h4B10, 16'hFC1C, 16'hF01D, 16'h4F01, 16'hFC1C},
                 2, {16'h0004, 16'h0014}, 16'd6);

        // short program whose two words behind HLT get flushed
        add_test("halt", 5,
                 {16'h4155, 16'hF41C, 16'hF01D, 16'h4166, 16'hF41C},
                 1, {16'h0055}, 16'd3);
endtask

`endif

// ==== sim/cpu_tb.sv ====
module cpu_tb;

        localparam int MAX_TESTS = 8;
        localparam int MAX_WORDS = 16;
        localparam int MAX_OUTS  = 4;
        localparam int SETTLE    = 10;   // cycles watched after the halt

        logic               clk;
        logic               reset_n;
        cpu_pkg::word_t     i_addr, i_data;
        cpu_pkg::dmem_req_t dmem_req;
        cpu_pkg::word_t     d_rdata;
        cpu_pkg::word_t     output_port;
        logic               halted;
        cpu_pkg::word_t     num_inst;

        cpu_pkg::word_t imem [256];
        cpu_pkg::word_t dmem [256];

        // test table with one row per program
        string          t_name  [MAX_TESTS];
        int             t_len   [MAX_TESTS];
        cpu_pkg::word_t t_prog  [MAX_TESTS][MAX_WORDS];
        int             t_nout  [MAX_TESTS];
        cpu_pkg::word_t t_out   [MAX_TESTS][MAX_OUTS];
        cpu_pkg::word_t t_count [MAX_TESTS];
        int             n_tests;

        cpu_pkg::word_t seen [$];   // every new value on the output port
        cpu_pkg::word_t last_out;

        cpu_core #(.RESET_PC(16'h0000)) uut (
                .clk           (clk),
                .reset_n       (reset_n),
                .o_i_address   (i_addr),
                .i_i_data      (i_data),
                .o_dmem        (dmem_req),
                .i_d_rdata     (d_rdata),
                .o_output_port (output_port),
                .o_halted      (halted),
                .o_num_inst    (num_inst)
        );

        always #10 clk = ~clk;

        // ------------------------------------------------------------
        // memory models answer in the same cycle
        // ------------------------------------------------------------
        assign i_data  = imem[i_addr[7:0]];
        assign d_rdata = dmem_req.read ? dmem[dmem_req.addr[7:0]] : '0;

        always @(posedge clk) begin
                if (dmem_req.write)
                        dmem[dmem_req.addr[7:0]] <= dmem_req.wdata;
        end

        function automatic logic [31:0] xorshift(input logic [31:0] x);
                logic [31:0] y;
                y = x ^ (x << 13);
                y = y ^ (y >> 17);
                y = y ^ (y << 5);
                return y;
        endfunction

        task automatic stop_with_failure(input string line);
                $display("%s", line);
                $display("Something failed");
                $fatal(1, "simulation stopped on the first error");
        endtask

        task automatic check_word(input string what, input cpu_pkg::word_t exp,
                                  input cpu_pkg::word_t act);
                if (act !== exp)
                        stop_with_failure($sformatf("Fail %s: expected %h, actual %h",
                                                    what, exp, act));
        endtask

        task automatic check_count(input string what, input cpu_pkg::word_t exp,
                                   input cpu_pkg::word_t act);
                if (act !== exp)
                        stop_with_failure($sformatf("Fail %s: expected %0d, actual %0d",
                                                    what, exp, act));
        endtask

        task automatic check_flag(input string what, input logic exp, input logic act);
                if (act !== exp)
                        stop_with_failure($sformatf("Fail %s: expected %b, actual %b",
                                                    what, exp, act));
        endtask

        // words and outputs arrive as concatenations with the first item in the top bits
        task automatic add_test(input string name, input int n_words, input logic [255:0] words,
                                input int n_outs, input logic [63:0] outs,
                                input cpu_pkg::word_t count);
                t_name[n_tests]  = name;
                t_len[n_tests]   = n_words;
                t_nout[n_tests]  = n_outs;
                t_count[n_tests] = count;
                for (int w = 0; w < n_words; w++)
                        t_prog[n_tests][w] = words[16*(n_words-1-w) +: 16];
                for (int k = 0; k < n_outs; k++)
                        t_out[n_tests][k] = outs[16*(n_outs-1-k) +: 16];
                n_tests++;
        endtask

        `include "cpu_tb_programs.svh"

        task automatic step_and_record();
                @(negedge clk);
                if (output_port !== last_out) begin
                        seen.push_back(output_port);
                        last_out = output_port;
                end
        endtask

        // ------------------------------------------------------------
        // run one program through reset and halt and compare
        // ------------------------------------------------------------
        task automatic run_test(input int t);
                int             cycles;
                int             limit;
                cpu_pkg::word_t halt_count;
                limit = 10 * t_len[t] + 20;
                for (int a = 0; a < 256; a++)
                        imem[a] = {8'h50, 8'(a)};   // ORI r0 filler that is never reached
                for (int w = 0; w < t_len[t]; w++)
                        imem[w] = t_prog[t][w];
                @(negedge clk);
                reset_n = 1'b0;
                repeat (8) @(negedge clk);
                check_flag({t_name[t], " halted in reset"}, 1'b0, halted);
                check_flag({t_name[t], " mem read in reset"}, 1'b0, dmem_req.read);
                check_flag({t_name[t], " mem write in reset"}, 1'b0, dmem_req.write);
                check_count({t_name[t], " count in reset"}, 16'd0, num_inst);
                check_word({t_name[t], " port in reset"}, 16'h0000, output_port);
                reset_n  = 1'b1;
                seen.delete();
                last_out = output_port;
                cycles   = 0;
                while (!halted) begin
                        step_and_record();
                        cycles++;
                        if (cycles > limit)
                                stop_with_failure($sformatf("%s: no halt within %0d cycles",
                                                            t_name[t], limit));
                end
                halt_count = num_inst;
                repeat (SETTLE) begin   // nothing may move once halted
                        step_and_record();
                        check_flag({t_name[t], " halt stays high"}, 1'b1, halted);
                        check_count({t_name[t], " count after halt"}, halt_count, num_inst);
                end
                if (seen.size() < t_nout[t])
                        stop_with_failure($sformatf("%s: only %0d of %0d outputs appeared",
                                                    t_name[t], seen.size(), t_nout[t]));
                else if (seen.size() > t_nout[t])
                        stop_with_failure($sformatf("%s: %0d outputs appeared, %0d expected",
                                                    t_name[t], seen.size(), t_nout[t]));
                for (int k = 0; k < t_nout[t]; k++)
                        check_word($sformatf("%s output %0d", t_name[t], k), t_out[t][k], seen[k]);
                check_count({t_name[t], " retired"}, t_count[t], num_inst);
        endtask

        initial begin
                logic [31:0] rng;
                clk      = 1'b0;
                reset_n  = 1'b0;
                n_tests  = 0;
                last_out = '0;
                rng      = 32'd10;
                for (int a = 0; a < 256; a++) begin
                        rng     = xorshift(rng);
                        dmem[a] = rng[15:0];
                end
                fill_test_table();   // load rows read dmem after the fill
                for (int t = 0; t < n_tests; t++)
                        run_test(t);
                $display("Everything OK");
                $finish;
        end

endmodule

// ==== filelist.f ====
+incdir+sim
source/cpu_pkg.sv
source/fetch_unit.sv
source/control_unit.sv
source/register_file.sv
source/execute_unit.sv
source/writeback_unit.sv
source/cpu_core.sv
sim/cpu_tb.sv

// ==== Makefile ====
VERILATOR  ?= verilator
TOP        := cpu_tb
FILELIST   := filelist.f
BUILD_DIR  := obj_dir
FLAGS      := --binary --timing -Wno-fatal -j 0
LINT_FLAGS := --lint-only -Wall --timing

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: build
	./$(BUILD_DIR)/V$(TOP)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)
